/* rst_pkg.sv */
// Reset-cause status block
// Shared types and register map

package rst_pkg;

  localparam int NUM_CAUSES = 4;

  // Bit 0 power, bit 1 watchdog, bit 2 software, bit 3 external
  typedef logic [NUM_CAUSES-1:0] cause_vec_t;
  typedef logic [1:0]            cause_idx_t;
  typedef logic [1:0]            reg_idx_t;
  typedef logic [31:0]           axi_addr_t;
  typedef logic [31:0]           axi_data_t;
  typedef logic [1:0]            axi_resp_t;
  typedef logic [7:0]            evt_count_t;

  // Register indices decoded from address bits 3:2
  localparam reg_idx_t REG_STATUS = 2'd0;
  localparam reg_idx_t REG_COUNT  = 2'd1;
  localparam reg_idx_t REG_LAST   = 2'd2;

  localparam axi_resp_t  RESP_OKAY = 2'b00;
  localparam evt_count_t COUNT_MAX = 8'd255;

  typedef struct packed {
    logic      strobe;
    reg_idx_t  idx;
    axi_data_t data;
  } reg_wr_t;

  typedef struct packed {
    logic       valid;
    cause_idx_t idx;
  } last_cause_t;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

endpackage

/* rst_cause_sync.sv */
// Reset-cause synchronizer and edge detect

module rst_cause_sync (
  input  logic               s_axi_aclk,
  input  logic               s_axi_aresetn,
  input  rst_pkg::cause_vec_t cause_in,
  output rst_pkg::cause_vec_t events
);

  rst_pkg::cause_vec_t sync_q1;
  rst_pkg::cause_vec_t sync_q2;
  rst_pkg::cause_vec_t hist_q;

  // Two-flop synchronizer chain plus one history stage
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      hist_q  <= '0;
    end else begin
      sync_q1 <= cause_in;
      sync_q2 <= sync_q1;
      hist_q  <= sync_q2;
    end
  end

  // Registered rising edge lasting one cycle
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      events <= '0;
    end else begin
      events <= sync_q2 & ~hist_q;
    end
  end

endmodule

/* rst_status_regs.sv */
// Reset-cause status registers

module rst_status_regs (
  input  logic                s_axi_aclk,
  input  logic                s_axi_aresetn,
  input  rst_pkg::cause_vec_t events,
  input  rst_pkg::reg_wr_t    reg_wr,
  input  rst_pkg::reg_idx_t   rd_idx,
  output rst_pkg::axi_data_t  rd_data
);

  rst_pkg::cause_vec_t  status;
  rst_pkg::evt_count_t  count;
  rst_pkg::last_cause_t last;

  logic any_evt;
  logic clr_status;
  logic clr_count;

  // Lowest set bit wins when causes coincide
  function automatic rst_pkg::cause_idx_t lowest_cause(input rst_pkg::cause_vec_t vec);
    rst_pkg::cause_idx_t idx;
    idx = '0;
    for (int i = rst_pkg::NUM_CAUSES - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = rst_pkg::cause_idx_t'(i);
      end
    end
    return idx;
  endfunction

  assign any_evt = |events;

  // Only an all-zero write to STATUS clears it
  assign clr_status = reg_wr.strobe && (reg_wr.idx == rst_pkg::REG_STATUS) &&
                      (reg_wr.data == '0);
  assign clr_count  = reg_wr.strobe && (reg_wr.idx == rst_pkg::REG_COUNT);

  // New events override a same-cycle clear of the sticky bits
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      status <= '0;
    end else if (clr_status) begin
      status <= events;
    end else begin
      status <= status | events;
    end
  end

  // Saturating event counter
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      count <= '0;
    end else if (any_evt) begin
      if (count != rst_pkg::COUNT_MAX) begin
        count <= count + 1'b1;
      end
    end else if (clr_count) begin
      count <= '0;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      last <= '0;
    end else if (any_evt) begin
      last.valid <= 1'b1;
      last.idx   <= lowest_cause(events);
    end else if (clr_status) begin
      last <= '0;
    end
  end

  // Unmapped indices read as zero
  always_comb begin
    rd_data = '0;
    case (rd_idx)
      rst_pkg::REG_STATUS: rd_data[rst_pkg::NUM_CAUSES-1:0] = status;
      rst_pkg::REG_COUNT:  rd_data[7:0] = count;
      rst_pkg::REG_LAST: begin
        rd_data[8]   = last.valid;
        rd_data[1:0] = last.idx;
      end
      default: rd_data = '0;
    endcase
  end

endmodule

/* rst_axil_slave.sv */
// AXI4-Lite slave for the status registers

module rst_axil_slave (
  input  logic                s_axi_aclk,
  input  logic                s_axi_aresetn,
  // Write address channel
  input  rst_pkg::axi_addr_t  s_axi_awaddr,
  input  logic                s_axi_awvalid,
  output logic                s_axi_awready,
  // Write data channel with ignored strobes
  input  rst_pkg::axi_data_t  s_axi_wdata,
  input  logic [3:0]          s_axi_wstrb,
  input  logic                s_axi_wvalid,
  output logic                s_axi_wready,
  // Write response channel
  output rst_pkg::axi_resp_t  s_axi_bresp,
  output logic                s_axi_bvalid,
  input  logic                s_axi_bready,
  // Read address channel
  input  rst_pkg::axi_addr_t  s_axi_araddr,
  input  logic                s_axi_arvalid,
  output logic                s_axi_arready,
  // Read data channel
  output rst_pkg::axi_data_t  s_axi_rdata,
  output rst_pkg::axi_resp_t  s_axi_rresp,
  output logic                s_axi_rvalid,
  input  logic                s_axi_rready,
  // Register side
  output rst_pkg::reg_wr_t    reg_wr,
  output rst_pkg::reg_idx_t   rd_idx,
  input  rst_pkg::axi_data_t  rd_data
);

  rst_pkg::wr_state_t wr_state;
  rst_pkg::rd_state_t rd_state;

  logic               wr_strobe;
  rst_pkg::reg_idx_t  wr_idx;
  rst_pkg::axi_data_t wr_data;

  assign s_axi_bresp = rst_pkg::RESP_OKAY;
  assign s_axi_rresp = rst_pkg::RESP_OKAY;

  assign reg_wr = '{strobe: wr_strobe, idx: wr_idx, data: wr_data};

  // Write channel FSM
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state      <= rst_pkg::WR_IDLE;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      wr_strobe     <= 1'b0;
    end else begin
      wr_strobe <= 1'b0;
      case (wr_state)
        rst_pkg::WR_IDLE: begin
          if (s_axi_awvalid) begin
            s_axi_awready <= 1'b1;
            wr_state      <= rst_pkg::WR_ADDR;
          end
        end
        rst_pkg::WR_ADDR: begin
          s_axi_awready <= 1'b0;
          s_axi_wready  <= 1'b1;
          wr_state      <= rst_pkg::WR_DATA;
        end
        rst_pkg::WR_DATA: begin
          if (s_axi_wvalid) begin
            s_axi_wready <= 1'b0;
            s_axi_bvalid <= 1'b1;
            wr_strobe    <= 1'b1;
            wr_state     <= rst_pkg::WR_RESP;
          end
        end
        rst_pkg::WR_RESP: begin
          // Hold the response until the master takes it
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            wr_state     <= rst_pkg::WR_IDLE;
          end
        end
        default: wr_state <= rst_pkg::WR_IDLE;
      endcase
    end
  end

  // Write address and data capture
  always_ff @(posedge s_axi_aclk) begin
    if (wr_state == rst_pkg::WR_IDLE && s_axi_awvalid) begin
      wr_idx <= s_axi_awaddr[3:2];
    end
    if (wr_state == rst_pkg::WR_DATA && s_axi_wvalid) begin
      wr_data <= s_axi_wdata;
    end
  end

  // Read channel FSM
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state      <= rst_pkg::RD_IDLE;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      s_axi_rdata   <= '0;
      rd_idx        <= '0;
    end else begin
      case (rd_state)
        rst_pkg::RD_IDLE: begin
          if (s_axi_arvalid) begin
            s_axi_arready <= 1'b1;
            rd_idx        <= s_axi_araddr[3:2];
            rd_state      <= rst_pkg::RD_ADDR;
          end
        end
        rst_pkg::RD_ADDR: begin
          s_axi_arready <= 1'b0;
          s_axi_rdata   <= rd_data;
          s_axi_rvalid  <= 1'b1;
          rd_state      <= rst_pkg::RD_DATA;
        end
        rst_pkg::RD_DATA: begin
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            rd_state     <= rst_pkg::RD_IDLE;
          end
        end
        default: rd_state <= rst_pkg::RD_IDLE;
      endcase
    end
  end

endmodule

/* rst_status_top.sv */
// Reset-cause status block top level

module rst_status_top (
  input  logic               s_axi_aclk,
  input  logic               s_axi_aresetn,
  input  rst_pkg::axi_addr_t s_axi_awaddr,
  input  logic               s_axi_awvalid,
  output logic               s_axi_awready,
  input  rst_pkg::axi_data_t s_axi_wdata,
  input  logic [3:0]         s_axi_wstrb,
  input  logic               s_axi_wvalid,
  output logic               s_axi_wready,
  output rst_pkg::axi_resp_t s_axi_bresp,
  output logic               s_axi_bvalid,
  input  logic               s_axi_bready,
  input  rst_pkg::axi_addr_t s_axi_araddr,
  input  logic               s_axi_arvalid,
  output logic               s_axi_arready,
  output rst_pkg::axi_data_t s_axi_rdata,
  output rst_pkg::axi_resp_t s_axi_rresp,
  output logic               s_axi_rvalid,
  input  logic               s_axi_rready,
  // Raw reset causes
  input  logic               pwr_rst,
  input  logic               wdt_rst,
  input  logic               sw_rst,
  input  logic               ext_rst
);

  rst_pkg::cause_vec_t cause_in;
  rst_pkg::cause_vec_t events;
  rst_pkg::reg_wr_t    reg_wr;
  rst_pkg::reg_idx_t   rd_idx;
  rst_pkg::axi_data_t  rd_data;

  assign cause_in = {ext_rst, sw_rst, wdt_rst, pwr_rst};

  rst_cause_sync u_sync (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .cause_in      (cause_in),
    .events        (events)
  );

  rst_status_regs u_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .events        (events),
    .reg_wr        (reg_wr),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  rst_axil_slave u_axil (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .reg_wr        (reg_wr),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

endmodule

/* rst_status_tb.sv */
// Testbench for the reset-cause status block

module rst_status_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 3000;

  logic               s_axi_aclk    = 1'b0;
  logic               s_axi_aresetn = 1'b0;
  rst_pkg::axi_addr_t s_axi_awaddr  = '0;
  logic               s_axi_awvalid = 1'b0;
  logic               s_axi_awready;
  rst_pkg::axi_data_t s_axi_wdata   = '0;
  logic [3:0]         s_axi_wstrb   = 4'hF;
  logic               s_axi_wvalid  = 1'b0;
  logic               s_axi_wready;
  rst_pkg::axi_resp_t s_axi_bresp;
  logic               s_axi_bvalid;
  logic               s_axi_bready  = 1'b0;
  rst_pkg::axi_addr_t s_axi_araddr  = '0;
  logic               s_axi_arvalid = 1'b0;
  logic               s_axi_arready;
  rst_pkg::axi_data_t s_axi_rdata;
  rst_pkg::axi_resp_t s_axi_rresp;
  logic               s_axi_rvalid;
  logic               s_axi_rready  = 1'b0;
  logic               pwr_rst       = 1'b0;
  logic               wdt_rst       = 1'b0;
  logic               sw_rst        = 1'b0;
  logic               ext_rst       = 1'b0;

  // Reference model of the three registers
  rst_pkg::cause_vec_t  m_status = '0;
  rst_pkg::evt_count_t  m_count  = '0;
  rst_pkg::last_cause_t m_last   = '0;

  int     data_errs = 0;
  int     resp_errs = 0;
  int     bit_errs  = 0;
  integer seed      = 60;

  rst_status_top dut (.*);

  always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

  task automatic check_data(input string name, input rst_pkg::axi_data_t got,
                            input rst_pkg::axi_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input rst_pkg::axi_resp_t got,
                            input rst_pkg::axi_resp_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      bit_errs++;
    end
  endtask

  // Causes fired together leave the smallest index in LAST
  task automatic model_event(input rst_pkg::cause_vec_t vec);
    logic found;
    found = 1'b0;
    m_status = m_status | vec;
    if (m_count != rst_pkg::COUNT_MAX) m_count = m_count + 1'b1;
    for (int i = 0; i < rst_pkg::NUM_CAUSES; i++) begin
      if (vec[i] && !found) begin
        m_last.idx = rst_pkg::cause_idx_t'(i);
        found = 1'b1;
      end
    end
    m_last.valid = 1'b1;
  endtask

  task automatic model_write(input rst_pkg::axi_addr_t addr, input rst_pkg::axi_data_t data);
    if (addr[3:2] == rst_pkg::REG_STATUS && data == '0) begin
      m_status = '0;
      m_last   = '0;
    end
    if (addr[3:2] == rst_pkg::REG_COUNT) m_count = '0;
  endtask

  function automatic rst_pkg::axi_data_t expected_read(input rst_pkg::reg_idx_t idx);
    case (idx)
      rst_pkg::REG_STATUS: return {28'h0, m_status};
      rst_pkg::REG_COUNT:  return {24'h0, m_count};
      rst_pkg::REG_LAST:   return {23'h0, m_last.valid, 6'h0, m_last.idx};
      default:             return '0;
    endcase
  endfunction

  // Raise the causes for two cycles, then let the event settle
  task automatic pulse_cause(input rst_pkg::cause_vec_t vec);
    {ext_rst, sw_rst, wdt_rst, pwr_rst} = vec;
    repeat (2) @(negedge s_axi_aclk);
    {ext_rst, sw_rst, wdt_rst, pwr_rst} = '0;
    repeat (6) @(negedge s_axi_aclk);
    model_event(vec);
  endtask

  task automatic axi_write(input rst_pkg::axi_addr_t addr, input rst_pkg::axi_data_t data,
                           input int hold);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    while (!s_axi_awready) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    s_axi_awvalid = 1'b0;
    while (!s_axi_wready) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    s_axi_wvalid = 1'b0;
    while (!s_axi_bvalid) @(negedge s_axi_aclk);
    check_resp("s_axi_bresp", s_axi_bresp, rst_pkg::RESP_OKAY);
    repeat (hold) begin
      @(negedge s_axi_aclk);
      check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
    end
    s_axi_bready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_bready = 1'b0;
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
    model_write(addr, data);
  endtask

  task automatic axi_read(input rst_pkg::axi_addr_t addr, input int hold,
                          output rst_pkg::axi_data_t data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge s_axi_aclk);
    data = s_axi_rdata;
    check_resp("s_axi_rresp", s_axi_rresp, rst_pkg::RESP_OKAY);
    // Data must not move while the master stalls
    repeat (hold) begin
      @(negedge s_axi_aclk);
      check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
      check_data("s_axi_rdata", s_axi_rdata, data);
    end
    s_axi_rready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_rready = 1'b0;
    check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
  endtask

  task automatic check_reg(input rst_pkg::reg_idx_t idx, input int hold);
    rst_pkg::axi_data_t got;
    axi_read({28'h0, idx, 2'b00}, hold, got);
    check_data("s_axi_rdata", got, expected_read(idx));
  endtask

  task automatic check_all_regs();
    check_reg(rst_pkg::REG_STATUS, 0);
    check_reg(rst_pkg::REG_COUNT, 0);
    check_reg(rst_pkg::REG_LAST, 0);
  endtask

  task automatic test_after_reset();
    check_bit("s_axi_awready", s_axi_awready, 1'b0);
    check_bit("s_axi_wready", s_axi_wready, 1'b0);
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_bit("s_axi_arready", s_axi_arready, 1'b0);
    check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_all_regs();
  endtask

  task automatic test_single_causes();
    for (int i = 0; i < rst_pkg::NUM_CAUSES; i++) begin
      pulse_cause(rst_pkg::cause_vec_t'(1 << i));
      check_all_regs();
    end
  endtask

  task automatic test_simultaneous();
    // Watchdog and external together
    pulse_cause(4'b1010);
    check_all_regs();
  endtask

  task automatic test_clearing();
    axi_write(32'h0, 32'h1, 0);
    check_all_regs();
    axi_write(32'h0, 32'h0, 0);
    check_all_regs();
    axi_write(32'h4, 32'h5A, 0);
    check_all_regs();
  endtask

  task automatic test_back_pressure();
    rst_pkg::axi_data_t got;
    pulse_cause(4'b0100);
    axi_read(32'hC, 4, got);
    check_data("s_axi_rdata", got, 32'h0);
    check_reg(rst_pkg::REG_STATUS, 5);
    axi_write(32'hC, 32'hFFFF_FFFF, 5);
    check_all_regs();
  endtask

  task automatic test_saturation();
    logic [31:0] r;
    axi_write(32'h0, 32'h0, 0);
    axi_write(32'h4, 32'h0, 0);
    repeat (260) begin
      r = $random(seed);
      pulse_cause(rst_pkg::cause_vec_t'(1 << r[1:0]));
    end
    check_all_regs();
  endtask

  // Watchdog sized from the test count and the per-test bound
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    repeat (16) @(negedge s_axi_aclk);
    s_axi_aresetn = 1'b1;
    @(negedge s_axi_aclk);
    test_after_reset();
    test_single_causes();
    test_simultaneous();
    test_clearing();
    test_back_pressure();
    test_saturation();
    $display("Errors: data %0d, response %0d, control %0d", data_errs, resp_errs, bit_errs);
    if (data_errs + resp_errs + bit_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* files.f */
rst_pkg.sv
rst_cause_sync.sv
rst_status_regs.sv
rst_axil_slave.sv
rst_status_top.sv
rst_status_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = rst_status_tb
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
